//--- logic/sys_pkg.sv
`default_nettype none

package sys_pkg;

	// ====================
	// Data widths
	// ====================
	typedef logic [31:0] gp_word_t;
	typedef logic [15:0] io_data_t;
	typedef logic signed [15:0] sample_t;

	// Bit 4 mutes, bits 3..0 are the right shift
	typedef logic [4:0] vol_att_t;
	typedef logic [7:0] cmd_code_t;

	// Host LED override, overtake in the high byte
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_cmd_t;

	// Power and disk as {enable, value}
	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_status_t;

	typedef struct packed {
		logic       is_signed;
		logic [1:0] mix;
	} audio_fmt_t;

	typedef enum logic {
		CMD_IDLE,
		CMD_ARG
	} cmd_state_t;

	// ====================
	// Host protocol
	// ====================
	localparam cmd_code_t CMD_LED = 8'h25;
	localparam cmd_code_t CMD_VOL = 8'h26;

	// Fixed signature, generic core type in the low byte
	localparam gp_word_t CORE_MAGIC = {24'h5CA623, 8'hA4};
	localparam logic [1:0] IO_VER = 2'd1;

	// Host word field positions
	localparam int HW_DATA_LSB = 0;
	localparam int HW_DATA_MSB = 15;
	localparam int HW_IO_CLK   = 17;
	localparam int HW_IO_UIO   = 20;
	localparam int HW_DISK     = 29;
	localparam int HW_RST_LSB  = 30;
	localparam int HW_RST_MSB  = 31;
	localparam int HW_READY    = 31;

endpackage

`default_nettype wire

//--- logic/host_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module host_cmd_ctrl (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  wire sys_pkg::gp_word_t gp_out,
	input  wire                    btn_user,
	input  wire                    btn_osd,
	output sys_pkg::gp_word_t      gp_in,
	output logic                   reset_req,
	output sys_pkg::led_cmd_t      led_cmd,
	output sys_pkg::vol_att_t      vol_att,
	output logic                   host_disk
);
	import sys_pkg::*;

	gp_word_t   gp_d;
	gp_word_t   gp_r;
	gp_word_t   status_word;
	io_data_t   io_din;
	logic       io_clk;
	logic       io_uio;
	logic       io_clk_d;
	logic       io_ack;
	logic       io_strobe;
	logic [1:0] rst_code;
	logic [1:0] rst_code_d;
	cmd_state_t state;
	cmd_code_t  cmd;

	// ====================
	// Host word input
	// ====================
	always_ff @(posedge clk_sys) begin
		gp_d <= gp_out;
		gp_r <= gp_d;
	end

	assign io_din    = gp_r[HW_DATA_MSB:HW_DATA_LSB];
	assign io_clk    = gp_r[HW_IO_CLK];
	assign io_uio    = gp_r[HW_IO_UIO];
	assign rst_code  = gp_r[HW_RST_MSB:HW_RST_LSB];
	assign host_disk = gp_r[HW_DISK];

	// Strobe on rising io_clk, ack trails it by two clocks
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_d <= 1'b0;
			io_ack   <= 1'b0;
		end else begin
			io_clk_d <= io_clk;
			io_ack   <= io_clk_d;
		end
	end

	assign io_strobe = io_clk & ~io_clk_d;

	// ====================
	// Command decoder
	// ====================
	// First strobe under io_uio is the command byte, later ones are arguments
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state   <= CMD_IDLE;
			cmd     <= '0;
			led_cmd <= '0;
			vol_att <= '0;
		end else if (!io_uio) begin
			state <= CMD_IDLE;
		end else if (io_strobe) begin
			case (state)
				CMD_IDLE: begin
					cmd   <= io_din[7:0];
					state <= CMD_ARG;
				end
				CMD_ARG: begin
					if (cmd == CMD_LED)
						led_cmd <= led_cmd_t'(io_din);
					if (cmd == CMD_VOL)
						vol_att <= io_din[4:0];
				end
				default: state <= CMD_IDLE;
			endcase
		end
	end

	// ====================
	// Reset request
	// ====================
	// Code 1 sets, code 2 right after code 0 clears
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			reset_req  <= 1'b0;
			rst_code_d <= 2'd0;
		end else begin
			rst_code_d <= rst_code;
			if (rst_code == 2'd1)
				reset_req <= 1'b1;
			else if (rst_code == 2'd2 && rst_code_d == 2'd0)
				reset_req <= 1'b0;
		end
	end

	// Status word back to the host
	assign status_word = {1'b0, btn_user, btn_osd, 9'd0, IO_VER, io_ack, 1'b0, 16'd0};

	// Host talks to the core only once it has seen the magic
	assign gp_in = gp_out[HW_READY] ? status_word : CORE_MAGIC;

endmodule

`default_nettype wire

//--- logic/btn_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module btn_debounce #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  btn_user_n,
	input  wire  btn_osd_n,
	output logic btn_user,
	output logic btn_osd
);
	localparam int DIV_W = $clog2(DEBOUNCE_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DEBOUNCE_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [1:0]       btn_raw;
	logic [1:0][7:0]  hist;
	logic [1:0]       btn_state;

	// Sample tick divider
	always_ff @(posedge clk_sys) begin
		if (resetd)
			div_cnt <= '0;
		else if (div_cnt == DIV_LAST)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign tick = (div_cnt == '0);

	// Index 0 is user, 1 is osd, both active high here
	assign btn_raw = {~btn_osd_n, ~btn_user_n};

	// State flips only on eight equal samples
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hist      <= '0;
			btn_state <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][6:0], btn_raw[i]};
				if (&hist[i])
					btn_state[i] <= 1'b1;
				else if (hist[i] == 8'd0)
					btn_state[i] <= 1'b0;
			end
		end
	end

	assign btn_user = btn_state[0];
	assign btn_osd  = btn_state[1];

endmodule

`default_nettype wire

//--- logic/led_driver.sv
`timescale 1ns/100ps
`default_nettype none

module led_driver (
	input  wire sys_pkg::led_status_t led_status,
	input  wire sys_pkg::led_cmd_t    led_cmd,
	input  wire                       host_disk,
	output logic                      led_power_en,
	output logic                      led_hdd_en,
	output logic                      led_user_en,
	output logic [7:0]                led_board
);
	logic [7:0] board_dflt;

	// ====================
	// Front LEDs
	// ====================
	// Enable high pulls the pin low and lights the LED
	assign led_power_en = led_status.power[1] ? led_status.power[0] : 1'b0;

	// Without core control the host disk activity shows too
	assign led_hdd_en = led_status.disk[1] ? led_status.disk[0]
		: (led_status.disk[0] | host_disk);

	assign led_user_en = led_status.user;

	// ====================
	// Board LEDs
	// ====================
	assign board_dflt = {3'b000, led_power_en, 1'b0, led_hdd_en, 1'b0, led_user_en};

	// Host override per bit
	assign led_board = (led_cmd.overtake & led_cmd.state)
		| (~led_cmd.overtake & board_dflt);

endmodule

`default_nettype wire

//--- logic/audio_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module audio_mixer (
	input  wire                      clk_sys,
	input  wire                      resetd,
	input  wire sys_pkg::sample_t    audio_l_in,
	input  wire sys_pkg::sample_t    audio_r_in,
	input  wire sys_pkg::audio_fmt_t audio_fmt,
	input  wire sys_pkg::vol_att_t   vol_att,
	output sys_pkg::sample_t         audio_l_out,
	output sys_pkg::sample_t         audio_r_out
);
	import sys_pkg::*;

	sample_t mix_l;
	sample_t mix_r;
	logic    mix_signed;

	// Arithmetic shift for signed samples, logical otherwise
	function automatic sample_t shr(input sample_t v, input logic [3:0] n, input logic arith);
		sample_t res;
		if (arith)
			res = v >>> n;
		else
			res = v >> n;
		return res;
	endfunction

	// Crossfeed of the other channel into this one
	function automatic sample_t mix_ch(input sample_t own, input sample_t other,
		input audio_fmt_t fmt);
		sample_t res;
		logic    sg;
		sg = fmt.is_signed;
		case (fmt.mix)
			2'd0: res = own;
			2'd1: res = own - shr(own, 4'd3, sg) + shr(other, 4'd3, sg);
			2'd2: res = own - shr(own, 4'd2, sg) + shr(other, 4'd2, sg);
			default: res = shr(own, 4'd1, sg) + shr(other, 4'd1, sg);
		endcase
		return res;
	endfunction

	// ====================
	// Stage 1 mix
	// ====================
	always_ff @(posedge clk_sys) begin
		mix_l      <= mix_ch(audio_l_in, audio_r_in, audio_fmt);
		mix_r      <= mix_ch(audio_r_in, audio_l_in, audio_fmt);
		mix_signed <= audio_fmt.is_signed;
	end

	// ====================
	// Stage 2 volume
	// ====================
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			audio_l_out <= '0;
			audio_r_out <= '0;
		end else if (vol_att[4]) begin
			// Mute
			audio_l_out <= '0;
			audio_r_out <= '0;
		end else begin
			audio_l_out <= shr(mix_l, vol_att[3:0], mix_signed);
			audio_r_out <= shr(mix_r, vol_att[3:0], mix_signed);
		end
	end

endmodule

`default_nettype wire

//--- logic/sync_polarity.sv
`timescale 1ns/100ps
`default_nettype none

module sync_polarity #(
	parameter int SYNC_CNT_W = 16
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  sync_in,
	output logic sync_out
);
	logic                  s1;
	logic                  s2;
	logic                  sync_rise;
	logic                  sync_fall;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
		end
	end

	assign sync_rise = s1 & ~s2;
	assign sync_fall = ~s1 & s2;

	// Phase lengths, latched at the edge that ends each phase
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			if (sync_rise || sync_fall)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			if (sync_rise)
				lo_len <= cnt;
			if (sync_fall)
				hi_len <= cnt;
			pol <= (hi_len > lo_len);
		end
	end

	// Long high phase means the pulse is active low
	assign sync_out = sync_in ^ pol;

endmodule

`default_nettype wire

//--- logic/sys_top.sv
`timescale 1ns/100ps
`default_nettype none

module sys_top #(
	parameter int DEBOUNCE_DIV = 100000,
	parameter int SYNC_CNT_W   = 16
) (
	input  wire                      clk_sys,
	input  wire                      resetd,
	// Host link
	input  wire sys_pkg::gp_word_t   gp_out,
	output sys_pkg::gp_word_t        gp_in,
	output logic                     reset_req,
	// Buttons, active low
	input  wire                      btn_user_n,
	input  wire                      btn_osd_n,
	// LEDs
	input  wire sys_pkg::led_status_t led_status,
	output logic                     led_power_en,
	output logic                     led_hdd_en,
	output logic                     led_user_en,
	output logic [7:0]               led_board,
	// Audio
	input  wire sys_pkg::sample_t    audio_l_in,
	input  wire sys_pkg::sample_t    audio_r_in,
	input  wire sys_pkg::audio_fmt_t audio_fmt,
	output sys_pkg::sample_t         audio_l_out,
	output sys_pkg::sample_t         audio_r_out,
	// Video sync
	input  wire                      hs_in,
	input  wire                      vs_in,
	output logic                     hs_out,
	output logic                     vs_out
);
	import sys_pkg::*;

	led_cmd_t led_cmd;
	vol_att_t vol_att;
	logic     host_disk;
	logic     btn_user;
	logic     btn_osd;

	// ====================
	// Control
	// ====================
	host_cmd_ctrl u_host_cmd_ctrl (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.gp_out    (gp_out),
		.btn_user  (btn_user),
		.btn_osd   (btn_osd),
		.gp_in     (gp_in),
		.reset_req (reset_req),
		.led_cmd   (led_cmd),
		.vol_att   (vol_att),
		.host_disk (host_disk)
	);

	btn_debounce #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) u_btn_debounce (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.btn_user_n (btn_user_n),
		.btn_osd_n  (btn_osd_n),
		.btn_user   (btn_user),
		.btn_osd    (btn_osd)
	);

	// ====================
	// Datapath
	// ====================
	led_driver u_led_driver (
		.led_status   (led_status),
		.led_cmd      (led_cmd),
		.host_disk    (host_disk),
		.led_power_en (led_power_en),
		.led_hdd_en   (led_hdd_en),
		.led_user_en  (led_user_en),
		.led_board    (led_board)
	);

	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.audio_l_in  (audio_l_in),
		.audio_r_in  (audio_r_in),
		.audio_fmt   (audio_fmt),
		.vol_att     (vol_att),
		.audio_l_out (audio_l_out),
		.audio_r_out (audio_r_out)
	);

	sync_polarity #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) u_sync_h (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (hs_in),
		.sync_out (hs_out)
	);

	sync_polarity #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) u_sync_v (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (vs_in),
		.sync_out (vs_out)
	);

endmodule

`default_nettype wire

//--- tests/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ====================
// Random source
// ====================
logic [31:0] lfsr_q = 32'hab37_622e;
int mismatch_cnt = 0;
int timeout_cnt = 0;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] res;
	logic        fb;
	res = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		res = {res[30:0], fb};
	end
	return res;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual) begin
		$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
		mismatch_cnt++;
	end
endtask

// ====================
// Reference models
// ====================
// One bit at a time, sign fill only for signed data
function automatic logic [15:0] shift_right(input logic [15:0] v, input int n, input logic arith);
	logic [15:0] r;
	r = v;
	for (int i = 0; i < n; i++)
		r = {arith & r[15], r[15:1]};
	return r;
endfunction

function automatic logic [15:0] mix_model(input logic [15:0] own, input logic [15:0] other,
	input logic sgn, input logic [1:0] mix);
	logic [15:0] res;
	case (mix)
		2'd0: res = own;
		2'd1: res = own - shift_right(own, 3, sgn) + shift_right(other, 3, sgn);
		2'd2: res = own - shift_right(own, 2, sgn) + shift_right(other, 2, sgn);
		default: res = shift_right(own, 1, sgn) + shift_right(other, 1, sgn);
	endcase
	return res;
endfunction

function automatic logic [15:0] vol_model(input logic [15:0] v, input logic [4:0] vol,
	input logic sgn);
	return vol[4] ? 16'd0 : shift_right(v, int'(vol[3:0]), sgn);
endfunction

// Result is {power, disk, user, board}
function automatic logic [10:0] led_model(input logic [4:0] st, input logic [15:0] cmd,
	input logic hdisk);
	logic       pwr;
	logic       dsk;
	logic [7:0] dflt;
	logic [7:0] board;
	pwr = st[3] & st[2];
	dsk = st[1] ? st[0] : (st[0] | hdisk);
	dflt = 8'd0;
	dflt[0] = st[4];
	dflt[2] = dsk;
	dflt[4] = pwr;
	for (int i = 0; i < 8; i++)
		board[i] = cmd[8 + i] ? cmd[i] : dflt[i];
	return {pwr, dsk, st[4], board};
endfunction

function automatic logic [31:0] status_model(input logic bu, input logic bo, input logic ack);
	return {1'b0, bu, bo, 9'd0, 2'd1, ack, 1'b0, 16'd0};
endfunction

`endif

//--- tests/tb_sys_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sys_top;
	import sys_pkg::*;

	logic        clk_sys;
	logic        resetd;
	gp_word_t    gp_out;
	gp_word_t    gp_in;
	logic        reset_req;
	logic        btn_user_n;
	logic        btn_osd_n;
	led_status_t led_status;
	logic        led_power_en;
	logic        led_hdd_en;
	logic        led_user_en;
	logic [7:0]  led_board;
	sample_t     audio_l_in;
	sample_t     audio_r_in;
	audio_fmt_t  audio_fmt;
	sample_t     audio_l_out;
	sample_t     audio_r_out;
	logic        hs_in;
	logic        vs_in;
	logic        hs_out;
	logic        vs_out;

	// Host word fields as the testbench drives them
	logic [1:0]  host_rst;
	logic        host_disk_bit;
	logic        host_uio;
	logic [15:0] led_cmd_tb;
	logic [4:0]  vol_tb;
	logic [31:0] exp_q[$];

	`include "tb_util.svh"

	sys_top #(
		.DEBOUNCE_DIV (15),
		.SYNC_CNT_W   (16)
	) u_dut (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.gp_in        (gp_in),
		.reset_req    (reset_req),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.led_status   (led_status),
		.led_power_en (led_power_en),
		.led_hdd_en   (led_hdd_en),
		.led_user_en  (led_user_en),
		.led_board    (led_board),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.audio_fmt    (audio_fmt),
		.audio_l_out  (audio_l_out),
		.audio_r_out  (audio_r_out),
		.hs_in        (hs_in),
		.vs_in        (vs_in),
		.hs_out       (hs_out),
		.vs_out       (vs_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ====================
	// Host link helpers
	// ====================
	task automatic step_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic drive_host(input logic clk_bit, input logic [15:0] data);
		@(posedge clk_sys);
		gp_out <= {host_rst, host_disk_bit, 8'd0, host_uio, 2'd0, clk_bit, 1'b0, data};
	endtask

	task automatic wait_status_bit(input int idx, input logic val, input int limit,
		input string what);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while (gp_in[idx] !== val && cnt < limit) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (gp_in[idx] !== val) begin
			$display("Timeout: %s did not happen in time", what);
			timeout_cnt++;
		end
	endtask

	task automatic wait_reset_req(input logic val);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while (reset_req !== val && cnt < 6) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (reset_req !== val) begin
			$display("Timeout: reset_req did not become %0b", val);
			timeout_cnt++;
		end
	endtask

	// One io_clk pulse paced by io_ack
	task automatic host_strobe(input logic [15:0] data);
		drive_host(1'b1, data);
		wait_status_bit(17, 1'b1, 5, "io_ack rise");
		drive_host(1'b0, data);
		wait_status_bit(17, 1'b0, 5, "io_ack fall");
	endtask

	task automatic send_cmd(input logic [7:0] code, input logic [15:0] arg);
		host_uio = 1'b1;
		host_strobe({8'd0, code});
		host_strobe(arg);
		host_uio = 1'b0;
		drive_host(1'b0, 16'd0);
		step_cycles(4);
	endtask

	task automatic check_leds(input string name);
		@(negedge clk_sys);
		check_value(name, led_model(led_status, led_cmd_tb, host_disk_bit),
			{led_power_en, led_hdd_en, led_user_en, led_board});
	endtask

	task automatic set_button(input int k, input logic val);
		@(posedge clk_sys);
		if (k == 0)
			btn_user_n <= val;
		else
			btn_osd_n <= val;
	endtask

	task automatic set_sync(input int which, input logic val);
		if (which == 0)
			hs_in <= val;
		else
			vs_in <= val;
	endtask

	// Three periods to settle and two checked
	task automatic run_sync(input int which);
		int    p;
		int    r;
		int    len;
		logic  idle;
		logic  act;
		string name;
		p = 3 + int'(rand_bits(3));
		r = p + 4 + int'(rand_bits(4));
		idle = rand_bits(1) != 0;
		name = (which == 0) ? "hs_polarity" : "vs_polarity";
		for (int per = 0; per < 5; per++) begin
			for (int ph = 0; ph < 2; ph++) begin
				len = (ph == 0) ? p : r;
				for (int c = 0; c < len; c++) begin
					@(posedge clk_sys);
					set_sync(which, (ph == 0) ? ~idle : idle);
					@(negedge clk_sys);
					if (per >= 3) begin
						act = (which == 0) ? hs_out : vs_out;
						check_value(name, (ph == 0), act);
					end
				end
			end
		end
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [15:0] arg;
		logic [15:0] l;
		logic [15:0] r;
		logic [2:0]  f;
		logic [31:0] exp;
		logic        seen;
		int          idx;
		int          len;

		resetd = 1'b1;
		gp_out = '0;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		led_status = '0;
		audio_l_in = '0;
		audio_r_in = '0;
		audio_fmt = '0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		host_rst = 2'd0;
		host_disk_bit = 1'b0;
		host_uio = 1'b0;
		led_cmd_tb = '0;
		vol_tb = '0;
		repeat (8) @(posedge clk_sys);
		resetd <= 1'b0;

		// Magic word and then the status word once the host is ready
		@(negedge clk_sys);
		check_value("magic", {24'h5CA623, 8'hA4}, gp_in);
		check_value("reset_req_init", 0, reset_req);
		host_rst = 2'd2;
		drive_host(1'b0, 16'd0);
		@(negedge clk_sys);
		check_value("status_idle", status_model(1'b0, 1'b0, 1'b0), gp_in);
		drive_host(1'b1, 16'd0);
		wait_status_bit(17, 1'b1, 5, "io_ack rise");
		check_value("status_ack", status_model(1'b0, 1'b0, 1'b1), gp_in);
		drive_host(1'b0, 16'd0);
		wait_status_bit(17, 1'b0, 5, "io_ack fall");

		// A command byte after io_uio drops must not land as data
		for (int i = 0; i < 4; i++) begin
			arg = 16'(rand_bits(16));
			send_cmd(CMD_LED, arg);
			led_cmd_tb = arg;
			step_cycles(5);
			check_leds("led_after_cmd_led");
			arg = 16'(rand_bits(16));
			send_cmd(CMD_VOL, arg);
			vol_tb = arg[4:0];
			step_cycles(5);
			check_leds("led_after_cmd_vol");
		end

		// LED rules
		for (int i = 0; i < 40; i++) begin
			@(posedge clk_sys);
			led_status <= led_status_t'(rand_bits(5));
			host_disk_bit = rand_bits(1) != 0;
			drive_host(1'b0, 16'd0);
			step_cycles(5);
			check_leds("led_rules");
		end

		// Audio in one batch per volume setting with batch 3 muted
		for (int b = 0; b < 6; b++) begin
			vol_tb = {(b == 3), 4'(rand_bits(4))};
			send_cmd(CMD_VOL, {11'd0, vol_tb});
			exp_q.delete();
			for (int c = 0; c < 40; c++) begin
				@(posedge clk_sys);
				l = 16'(rand_bits(16));
				r = 16'(rand_bits(16));
				f = 3'(rand_bits(3));
				audio_l_in <= l;
				audio_r_in <= r;
				audio_fmt <= f;
				exp_q.push_back({vol_model(mix_model(l, r, f[2], f[1:0]), vol_tb, f[2]),
					vol_model(mix_model(r, l, f[2], f[1:0]), vol_tb, f[2])});
				@(negedge clk_sys);
				if (exp_q.size() > 2) begin
					exp = exp_q.pop_front();
					check_value("audio", exp, {audio_l_out, audio_r_out});
				end
			end
		end

		// Debounce of user and then osd
		for (int k = 0; k < 2; k++) begin
			idx = (k == 0) ? 30 : 29;
			set_button(k, 1'b0);
			wait_status_bit(idx, 1'b1, 300, "button press");
			set_button(k, 1'b1);
			wait_status_bit(idx, 1'b0, 300, "button release");
			len = 15 + int'(rand_bits(6));
			set_button(k, 1'b0);
			seen = 1'b0;
			for (int c = 0; c < len + 200; c++) begin
				if (c == len)
					set_button(k, 1'b1);
				else
					@(posedge clk_sys);
				@(negedge clk_sys);
				seen = seen | gp_in[idx];
			end
			check_value("button_glitch", 0, seen);
		end

		// Reset code tracker
		host_rst = 2'd1;
		drive_host(1'b0, 16'd0);
		wait_reset_req(1'b1);
		host_rst = 2'd2;
		drive_host(1'b0, 16'd0);
		step_cycles(6);
		@(negedge clk_sys);
		check_value("reset_req_hold_2", 1, reset_req);
		host_rst = 2'd0;
		drive_host(1'b0, 16'd0);
		step_cycles(6);
		@(negedge clk_sys);
		check_value("reset_req_hold_0", 1, reset_req);
		host_rst = 2'd2;
		drive_host(1'b0, 16'd0);
		wait_reset_req(1'b0);

		// Sync polarity alternating between h and v
		for (int t = 0; t < 4; t++)
			run_sync(t % 2);

		$display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tests
logic/sys_pkg.sv
logic/host_cmd_ctrl.sv
logic/btn_debounce.sv
logic/led_driver.sv
logic/audio_mixer.sv
logic/sync_polarity.sv
logic/sys_top.sv
tests/tb_sys_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, result taken from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sys_top -f filelist.f -o tb_sys_top \
	&& ./obj_dir/tb_sys_top | tee sim.log
grep -q "SIMULATION PASSED" sim.log \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
